/* rtl/cpu_cfg_pkg.sv */
package cpu_cfg_pkg;

	localparam int word_w = 32; // data word
	localparam int pc_w   = 22; // program counter and bus word address
	localparam int reg_aw = 5;  // register index

	// JR through this register returns via the link register
	localparam logic [reg_aw-1:0] link_reg = 5'd29;

endpackage

/* rtl/cpu_isa_pkg.sv */
package cpu_isa_pkg;

	// opcodes in instr[31:27]
	localparam logic [4:0] op_add  = 5'b00000;
	localparam logic [4:0] op_addi = 5'b00001;
	localparam logic [4:0] op_sub  = 5'b00010;
	localparam logic [4:0] op_subi = 5'b00011;
	localparam logic [4:0] op_lw   = 5'b00100;
	localparam logic [4:0] op_sw   = 5'b00101;
	localparam logic [4:0] op_mov  = 5'b00110;
	localparam logic [4:0] op_movi = 5'b00111;
	localparam logic [4:0] op_and  = 5'b01000;
	localparam logic [4:0] op_or   = 5'b01001;
	localparam logic [4:0] op_nor  = 5'b01010;
	localparam logic [4:0] op_sll  = 5'b01011;
	localparam logic [4:0] op_srl  = 5'b01100;
	localparam logic [4:0] op_sra  = 5'b01101;
	localparam logic [4:0] op_b    = 5'b01110;
	localparam logic [4:0] op_jr   = 5'b10000;
	localparam logic [4:0] op_jal  = 5'b10001;
	localparam logic [4:0] op_halt = 5'b11111;

	localparam logic [2:0] alu_add = 3'b000;
	localparam logic [2:0] alu_sub = 3'b001;
	localparam logic [2:0] alu_and = 3'b010;
	localparam logic [2:0] alu_or  = 3'b011;
	localparam logic [2:0] alu_nor = 3'b100;
	localparam logic [2:0] alu_sll = 3'b101;
	localparam logic [2:0] alu_srl = 3'b110;
	localparam logic [2:0] alu_sra = 3'b111;

	// branch conditions in instr[26:24]
	localparam logic [2:0] cond_neq    = 3'b000;
	localparam logic [2:0] cond_eq     = 3'b001;
	localparam logic [2:0] cond_gt     = 3'b010;
	localparam logic [2:0] cond_lt     = 3'b011;
	localparam logic [2:0] cond_gte    = 3'b100;
	localparam logic [2:0] cond_lte    = 3'b101;
	localparam logic [2:0] cond_ovfl   = 3'b110;
	localparam logic [2:0] cond_uncond = 3'b111;

	localparam int op_hi    = 31;
	localparam int op_lo    = 27;
	localparam int cond_hi  = 26;
	localparam int cond_lo  = 24;
	localparam int dst_hi   = 26;
	localparam int dst_lo   = 22;
	localparam int rs_hi    = 21;
	localparam int rs_lo    = 17;
	localparam int rt_hi    = 16;
	localparam int rt_lo    = 12;
	localparam int imm_hi   = 16; // sign bit of the immediate
	localparam int imm_lo   = 0;
	localparam int label_hi = 21;
	localparam int label_lo = 0;

endpackage

/* rtl/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic [cpu_cfg_pkg::reg_aw-1:0] rs_addr,
	input  logic [cpu_cfg_pkg::reg_aw-1:0] rt_addr,
	input  logic [cpu_cfg_pkg::reg_aw-1:0] dbg_addr,
	input  logic                           we,
	input  logic [cpu_cfg_pkg::reg_aw-1:0] wa,
	input  logic [cpu_cfg_pkg::word_w-1:0] wd,
	output logic [cpu_cfg_pkg::word_w-1:0] rs_data,
	output logic [cpu_cfg_pkg::word_w-1:0] rt_data,
	output logic [cpu_cfg_pkg::word_w-1:0] dbg_data
);
	import cpu_cfg_pkg::*;

	localparam int n_regs = 1 << reg_aw;

	logic [word_w-1:0] regs [n_regs];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < n_regs; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (wa != '0)) begin
			regs[wa] <= wd; // r0 is never written
		end
	end

	// asynchronous reads
	assign rs_data  = regs[rs_addr];
	assign rt_data  = regs[rt_addr];
	assign dbg_data = regs[dbg_addr]; // valid any time, meant for use after halt

endmodule

/* rtl/instr_decode.sv */
`timescale 1ns/1ps

module instr_decode (
	input  logic [cpu_cfg_pkg::word_w-1:0] instr,
	output logic [cpu_cfg_pkg::reg_aw-1:0] rs_addr,
	output logic [cpu_cfg_pkg::reg_aw-1:0] rt_addr,
	output logic [cpu_cfg_pkg::reg_aw-1:0] dst_reg,
	output logic [cpu_cfg_pkg::word_w-1:0] imm,
	output logic [2:0]                     alu_op,
	output logic                           use_imm,
	output logic                           use_dst_reg,
	output logic                           upd_neg,
	output logic                           upd_carry,
	output logic                           upd_ovf,
	output logic                           upd_zero,
	output logic                           mem_re,
	output logic                           mem_we,
	output logic                           is_branch,
	output logic                           is_jr,
	output logic                           is_jal,
	output logic                           hlt
);
	import cpu_cfg_pkg::*;
	import cpu_isa_pkg::*;

	logic [4:0] opcode;

	assign opcode  = instr[op_hi:op_lo];
	assign dst_reg = instr[dst_hi:dst_lo];
	assign imm     = {{(word_w - imm_hi - 1){instr[imm_hi]}}, instr[imm_hi:imm_lo]};

	always_comb begin
		rs_addr     = instr[rs_hi:rs_lo];
		rt_addr     = instr[rt_hi:rt_lo];
		alu_op      = alu_add;
		use_imm     = 1'b0;
		use_dst_reg = 1'b0;
		upd_neg     = 1'b0;
		upd_carry   = 1'b0;
		upd_ovf     = 1'b0;
		upd_zero    = 1'b0;
		mem_re      = 1'b0;
		mem_we      = 1'b0;
		is_branch   = 1'b0;
		is_jr       = 1'b0;
		is_jal      = 1'b0;
		hlt         = 1'b0;

		case (opcode)
			op_add, op_addi, op_sub, op_subi: begin
				use_dst_reg = 1'b1;
				use_imm     = opcode[0]; // odd opcodes take the immediate
				alu_op      = opcode[1] ? alu_sub : alu_add;
				upd_neg     = 1'b1;
				upd_carry   = 1'b1;
				upd_ovf     = 1'b1;
				upd_zero    = 1'b1;
			end
			op_lw: begin
				use_imm     = 1'b1; // address is rs + imm
				use_dst_reg = 1'b1;
				mem_re      = 1'b1;
			end
			op_sw: begin
				rt_addr = instr[dst_hi:dst_lo]; // store data comes from the dst field
				use_imm = 1'b1;
				mem_we  = 1'b1;
			end
			op_mov: begin
				rt_addr     = '0; // rs + r0
				use_dst_reg = 1'b1;
			end
			op_movi: begin
				rs_addr     = '0; // behaves as r0 + imm
				use_imm     = 1'b1;
				use_dst_reg = 1'b1;
			end
			op_and, op_or, op_nor: begin
				use_dst_reg = 1'b1;
				upd_zero    = 1'b1;
				alu_op      = (opcode == op_and) ? alu_and :
				              (opcode == op_or)  ? alu_or : alu_nor;
			end
			op_sll: begin
				use_imm     = 1'b1;
				use_dst_reg = 1'b1;
				upd_zero    = 1'b1;
				upd_ovf     = 1'b1; // sign change on shift out
				alu_op      = alu_sll;
			end
			op_srl, op_sra: begin
				use_imm     = 1'b1;
				use_dst_reg = 1'b1;
				upd_zero    = 1'b1;
				alu_op      = (opcode == op_srl) ? alu_srl : alu_sra;
			end
			op_b: begin
				is_branch = 1'b1;
			end
			op_jr: begin
				rs_addr = instr[dst_hi:dst_lo]; // jump register sits in the dst field
				is_jr   = 1'b1;
			end
			op_jal: begin
				is_branch = 1'b1;
				is_jal    = 1'b1;
			end
			op_halt: begin
				hlt = 1'b1;
			end
			default: begin
				// sprite and unknown opcodes fall through as no-ops
			end
		endcase
	end

endmodule

/* rtl/alu_execute.sv */
`timescale 1ns/1ps

module alu_execute (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           exec_en,
	input  logic [cpu_cfg_pkg::word_w-1:0] rs_data,
	input  logic [cpu_cfg_pkg::word_w-1:0] rt_data,
	input  logic [cpu_cfg_pkg::word_w-1:0] imm,
	input  logic [2:0]                     alu_op,
	input  logic                           use_imm,
	input  logic                           upd_neg,
	input  logic                           upd_carry,
	input  logic                           upd_ovf,
	input  logic                           upd_zero,
	input  logic                           is_branch,
	input  logic                           is_jr,
	input  logic                           jr_link,
	input  logic [cpu_cfg_pkg::pc_w-1:0]   link_pc,
	input  logic [cpu_cfg_pkg::pc_w-1:0]   label,
	input  logic [2:0]                     cond,
	output logic [cpu_cfg_pkg::word_w-1:0] alu_result,
	output logic                           branch_taken,
	output logic [cpu_cfg_pkg::pc_w-1:0]   branch_target
);
	import cpu_cfg_pkg::*;
	import cpu_isa_pkg::*;

	localparam int msb     = word_w - 1;
	localparam int shamt_w = $clog2(word_w);

	logic [word_w-1:0]  op_b;
	logic [shamt_w-1:0] shamt;
	logic [word_w:0]    sum_ext;
	logic               carry;
	logic               ovf;
	logic               flag_n, flag_c, flag_v, flag_z;
	logic               cond_ok;

	assign op_b  = use_imm ? imm : rt_data;
	assign shamt = op_b[shamt_w-1:0];

	always_comb begin
		sum_ext    = '0;
		carry      = 1'b0;
		ovf        = 1'b0;
		alu_result = '0;
		case (alu_op)
			alu_add: begin
				sum_ext    = {1'b0, rs_data} + {1'b0, op_b};
				alu_result = sum_ext[msb:0];
				carry      = sum_ext[word_w];
				ovf        = (rs_data[msb] == op_b[msb]) && (alu_result[msb] != rs_data[msb]);
			end
			alu_sub: begin
				sum_ext    = {1'b0, rs_data} + {1'b0, ~op_b} + {{word_w{1'b0}}, 1'b1};
				alu_result = sum_ext[msb:0];
				carry      = sum_ext[word_w]; // set when no borrow
				ovf        = (rs_data[msb] != op_b[msb]) && (alu_result[msb] != rs_data[msb]);
			end
			alu_and: alu_result = rs_data & op_b;
			alu_or:  alu_result = rs_data | op_b;
			alu_nor: alu_result = ~(rs_data | op_b);
			alu_sll: begin
				alu_result = rs_data << shamt;
				ovf        = alu_result[msb] != rs_data[msb];
			end
			alu_srl: alu_result = rs_data >> shamt;
			default: alu_result = $signed(rs_data) >>> shamt; // sra
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			flag_n <= 1'b0;
			flag_c <= 1'b0;
			flag_v <= 1'b0;
			flag_z <= 1'b0;
		end else if (exec_en) begin
			if (upd_neg)   flag_n <= alu_result[msb];
			if (upd_carry) flag_c <= carry;
			if (upd_ovf)   flag_v <= ovf;
			if (upd_zero)  flag_z <= (alu_result == '0);
		end
	end

	// conditions test the stored flags only
	always_comb begin
		case (cond)
			cond_neq:  cond_ok = ~flag_z;
			cond_eq:   cond_ok = flag_z;
			cond_gt:   cond_ok = ~flag_n & ~flag_z;
			cond_lt:   cond_ok = flag_n & ~flag_z;
			cond_gte:  cond_ok = ~flag_n | flag_z;
			cond_lte:  cond_ok = flag_n | flag_z;
			cond_ovfl: cond_ok = flag_v;
			default:   cond_ok = 1'b1; // uncond and jal
		endcase
	end

	assign branch_taken  = is_jr | (is_branch & cond_ok);
	assign branch_target = (is_jr && jr_link) ? link_pc :
	                       is_jr ? rs_data[pc_w-1:0] : label;

endmodule

/* rtl/result_writeback.sv */
`timescale 1ns/1ps

module result_writeback (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           wb_en,
	input  logic                           exec_en,
	input  logic                           is_jal,
	input  logic [cpu_cfg_pkg::pc_w-1:0]   next_pc,
	input  logic [cpu_cfg_pkg::word_w-1:0] alu_result,
	input  logic [cpu_cfg_pkg::word_w-1:0] load_data,
	input  logic                           mem_re,
	input  logic                           use_dst_reg,
	input  logic [cpu_cfg_pkg::reg_aw-1:0] dst_reg,
	output logic [cpu_cfg_pkg::pc_w-1:0]   link_pc,
	output logic                           reg_we,
	output logic [cpu_cfg_pkg::reg_aw-1:0] reg_wa,
	output logic [cpu_cfg_pkg::word_w-1:0] reg_wd
);
	import cpu_cfg_pkg::*;

	// return address lives here, not in r29
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			link_pc <= '0;
		end else if (exec_en && is_jal) begin
			link_pc <= next_pc;
		end
	end

	assign reg_we = wb_en & use_dst_reg;
	assign reg_wa = dst_reg;
	assign reg_wd = mem_re ? load_data : alu_result; // loads return bus data

endmodule

/* rtl/fetch_bus_unit.sv */
`timescale 1ns/1ps

module fetch_bus_unit #(
	parameter logic [cpu_cfg_pkg::pc_w-1:0] reset_pc = '0
) (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           mem_re,
	input  logic                           mem_we,
	input  logic                           hlt,
	input  logic                           branch_taken,
	input  logic [cpu_cfg_pkg::pc_w-1:0]   branch_target,
	input  logic [cpu_cfg_pkg::word_w-1:0] addr,
	input  logic [cpu_cfg_pkg::word_w-1:0] store_data,
	input  logic [cpu_cfg_pkg::word_w-1:0] wb_dat_i,
	input  logic                           wb_ack,
	output logic [cpu_cfg_pkg::word_w-1:0] instr,
	output logic [cpu_cfg_pkg::pc_w-1:0]   next_pc,
	output logic [cpu_cfg_pkg::word_w-1:0] load_data,
	output logic                           exec_en,
	output logic                           wb_en,
	output logic                           halted,
	output logic                           wb_cyc,
	output logic                           wb_stb,
	output logic                           wb_we,
	output logic [cpu_cfg_pkg::pc_w-1:0]   wb_adr,
	output logic [cpu_cfg_pkg::word_w-1:0] wb_dat_o
);
	import cpu_cfg_pkg::*;

	typedef enum logic [2:0] {st_fetch, st_exec, st_mem, st_wb, st_halted} state_t;

	state_t          state;
	logic [pc_w-1:0] pc;
	logic [pc_w-1:0] pc_nxt;
	logic            bus_req; // cyc and stb move together

	assign next_pc = pc + pc_w'(1);
	assign pc_nxt  = branch_taken ? branch_target : next_pc;
	assign exec_en = (state == st_exec);
	assign wb_en   = (state == st_wb);
	assign wb_cyc  = bus_req;
	assign wb_stb  = bus_req;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= st_fetch;
			pc      <= reset_pc;
			halted  <= 1'b0;
			bus_req <= 1'b0;
			wb_we   <= 1'b0;
		end else begin
			case (state)
				st_fetch: begin
					if (!bus_req) begin
						bus_req <= 1'b1; // first fetch after reset
					end else if (wb_ack) begin
						bus_req <= 1'b0;
						state   <= st_exec;
					end
				end
				st_exec: begin
					if (hlt) begin
						halted <= 1'b1;
						state  <= st_halted;
					end else if (mem_re || mem_we) begin
						bus_req <= 1'b1;
						wb_we   <= mem_we;
						state   <= st_mem;
					end else begin
						state <= st_wb;
					end
				end
				st_mem: begin
					if (wb_ack) begin
						bus_req <= 1'b0;
						wb_we   <= 1'b0;
						state   <= st_wb;
					end
				end
				st_wb: begin
					pc      <= pc_nxt;
					bus_req <= 1'b1; // next fetch opens right away
					state   <= st_fetch;
				end
				st_halted: begin
					// parked until reset
				end
				default: state <= st_fetch;
			endcase
		end
	end

	// bus address, write data and returned words
	always_ff @(posedge clk) begin
		if (state == st_wb) begin
			wb_adr <= pc_nxt;
		end else if (state == st_fetch && !bus_req) begin
			wb_adr <= pc;
		end else if (state == st_exec) begin
			wb_adr   <= addr[pc_w-1:0];
			wb_dat_o <= store_data;
		end
		if (bus_req && wb_ack) begin
			if (state == st_fetch) instr <= wb_dat_i;
			else load_data <= wb_dat_i;
		end
	end

endmodule

/* rtl/mini_cpu_core.sv */
`timescale 1ns/1ps

module mini_cpu_core #(
	parameter logic [cpu_cfg_pkg::pc_w-1:0] reset_pc = '0
) (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic [cpu_cfg_pkg::word_w-1:0] wb_dat_i,
	input  logic                           wb_ack,
	input  logic [cpu_cfg_pkg::reg_aw-1:0] dbg_addr,
	output logic                           wb_cyc,
	output logic                           wb_stb,
	output logic                           wb_we,
	output logic [cpu_cfg_pkg::pc_w-1:0]   wb_adr,
	output logic [cpu_cfg_pkg::word_w-1:0] wb_dat_o,
	output logic                           halted,
	output logic [cpu_cfg_pkg::word_w-1:0] dbg_data
);
	import cpu_cfg_pkg::*;
	import cpu_isa_pkg::*;

	logic [word_w-1:0] instr, imm, rs_data, rt_data, alu_result, load_data, reg_wd;
	logic [reg_aw-1:0] rs_addr, rt_addr, dst_reg, reg_wa;
	logic [pc_w-1:0]   branch_target, link_pc, next_pc;
	logic [2:0]        alu_op, cond;
	logic              use_imm, use_dst_reg, mem_re, mem_we, hlt;
	logic              upd_neg, upd_carry, upd_ovf, upd_zero;
	logic              is_branch, is_jr, is_jal, jr_link, branch_taken;
	logic              exec_en, wb_en, reg_we;

	assign jr_link = (rs_addr == link_reg); // jr names r29
	assign cond    = is_jal ? cond_uncond : instr[cond_hi:cond_lo];

	reg_file u_reg_file (
		.clk(clk), .rst_n(rst_n), .rs_addr(rs_addr), .rt_addr(rt_addr),
		.dbg_addr(dbg_addr), .we(reg_we), .wa(reg_wa), .wd(reg_wd),
		.rs_data(rs_data), .rt_data(rt_data), .dbg_data(dbg_data)
	);

	instr_decode u_decode (
		.instr(instr), .rs_addr(rs_addr), .rt_addr(rt_addr), .dst_reg(dst_reg), .imm(imm),
		.alu_op(alu_op), .use_imm(use_imm), .use_dst_reg(use_dst_reg), .upd_neg(upd_neg),
		.upd_carry(upd_carry), .upd_ovf(upd_ovf), .upd_zero(upd_zero), .mem_re(mem_re),
		.mem_we(mem_we), .is_branch(is_branch), .is_jr(is_jr), .is_jal(is_jal), .hlt(hlt)
	);

	alu_execute u_execute (
		.clk(clk), .rst_n(rst_n), .exec_en(exec_en), .rs_data(rs_data), .rt_data(rt_data),
		.imm(imm), .alu_op(alu_op), .use_imm(use_imm), .upd_neg(upd_neg),
		.upd_carry(upd_carry), .upd_ovf(upd_ovf), .upd_zero(upd_zero),
		.is_branch(is_branch), .is_jr(is_jr), .jr_link(jr_link), .link_pc(link_pc),
		.label(instr[label_hi:label_lo]), .cond(cond), .alu_result(alu_result),
		.branch_taken(branch_taken), .branch_target(branch_target)
	);

	result_writeback u_writeback (
		.clk(clk), .rst_n(rst_n), .wb_en(wb_en), .exec_en(exec_en), .is_jal(is_jal),
		.next_pc(next_pc), .alu_result(alu_result), .load_data(load_data), .mem_re(mem_re),
		.use_dst_reg(use_dst_reg), .dst_reg(dst_reg), .link_pc(link_pc),
		.reg_we(reg_we), .reg_wa(reg_wa), .reg_wd(reg_wd)
	);

	fetch_bus_unit #(
		.reset_pc(reset_pc)
	) u_fetch_bus (
		.clk(clk), .rst_n(rst_n), .mem_re(mem_re), .mem_we(mem_we), .hlt(hlt),
		.branch_taken(branch_taken), .branch_target(branch_target), .addr(alu_result),
		.store_data(rt_data), .wb_dat_i(wb_dat_i), .wb_ack(wb_ack), .instr(instr),
		.next_pc(next_pc), .load_data(load_data), .exec_en(exec_en), .wb_en(wb_en),
		.halted(halted), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
		.wb_adr(wb_adr), .wb_dat_o(wb_dat_o)
	);

endmodule

/* testbench/tb_bus_memory.sv */
`timescale 1ns/1ps

module tb_bus_memory (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           cyc,
	input  logic                           stb,
	input  logic                           we,
	input  logic [cpu_cfg_pkg::pc_w-1:0]   adr,
	input  logic [cpu_cfg_pkg::word_w-1:0] wr_data,
	output logic [cpu_cfg_pkg::word_w-1:0] rd_data,
	output logic                           ack,
	input  logic                           load_en,
	input  logic [7:0]                     load_adr,
	input  logic [cpu_cfg_pkg::word_w-1:0] load_dat
);
	import cpu_cfg_pkg::*;

	localparam logic [31:0] seed = 32'h39d992e5;

	logic [word_w-1:0] mem [256];
	logic [31:0]       rnd;
	logic [1:0]        wait_cnt;
	logic              busy;      // request seen, counting wait states
	logic              hit;
	logic [4:0]        st_cnt;    // stores logged since reset
	logic [pc_w-1:0]   st_adr [16];
	logic [word_w-1:0] st_dat [16];

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	assign hit = cyc && stb && !ack && busy && (wait_cnt == 2'd0);

	// program loader port wins over bus writes
	always_ff @(posedge clk) begin
		if (load_en) begin
			mem[load_adr] <= load_dat;
		end else if (hit && we) begin
			mem[adr[7:0]] <= wr_data;
		end
		rd_data <= mem[adr[7:0]]; // valid together with ack
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ack      <= 1'b0;
			busy     <= 1'b0;
			wait_cnt <= 2'd0;
			rnd      <= seed;
			st_cnt   <= '0;
		end else begin
			ack <= 1'b0; // single cycle ack
			if (cyc && stb && !ack) begin
				if (!busy) begin
					busy     <= 1'b1;
					wait_cnt <= rnd[1:0]; // 0 to 3 wait states
					rnd      <= xorshift(rnd);
				end else if (wait_cnt != 2'd0) begin
					wait_cnt <= wait_cnt - 2'd1;
				end else begin
					ack  <= 1'b1;
					busy <= 1'b0;
					if (we) begin
						st_adr[st_cnt[3:0]] <= adr;
						st_dat[st_cnt[3:0]] <= wr_data;
						st_cnt              <= st_cnt + 5'd1;
					end
				end
			end
		end
	end

endmodule

/* testbench/tb_mini_cpu_core.sv */
`timescale 1ns/1ps

module tb_mini_cpu_core;
	import cpu_cfg_pkg::*;
	import cpu_isa_pkg::*;

	localparam int prog_words = 64;

	logic              clk = 1'b0;
	logic              rst_n;
	logic [reg_aw-1:0] dbg_addr;
	logic [word_w-1:0] dbg_data;
	logic              wb_cyc, wb_stb, wb_we, wb_ack, halted;
	logic [pc_w-1:0]   wb_adr;
	logic [word_w-1:0] wb_dat_o, wb_dat_i;
	logic              load_en;
	logic [7:0]        load_adr;
	logic [word_w-1:0] load_dat;
	logic [word_w-1:0] prog [prog_words];
	int                prog_len;
	int                errors;
	int                checks;

	always #4 clk = ~clk; // 8 ns period

	mini_cpu_core #(
		.reset_pc(22'd0)
	) uut (
		.clk(clk), .rst_n(rst_n), .wb_dat_i(wb_dat_i), .wb_ack(wb_ack), .dbg_addr(dbg_addr),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_o(wb_dat_o), .halted(halted), .dbg_data(dbg_data)
	);

	tb_bus_memory mem (
		.clk(clk), .rst_n(rst_n), .cyc(wb_cyc), .stb(wb_stb), .we(wb_we), .adr(wb_adr),
		.wr_data(wb_dat_o), .rd_data(wb_dat_i), .ack(wb_ack), .load_en(load_en),
		.load_adr(load_adr), .load_dat(load_dat)
	);

	function automatic logic [word_w-1:0] sext17(input logic [16:0] v);
		return {{15{v[16]}}, v};
	endfunction

	function automatic logic [word_w-1:0] r_type(input logic [4:0] op, input logic [4:0] d,
		input logic [4:0] s, input logic [4:0] t);
		return {op, d, s, t, 12'd0};
	endfunction

	function automatic logic [word_w-1:0] i_type(input logic [4:0] op, input logic [4:0] d,
		input logic [4:0] s, input logic [16:0] imm);
		return {op, d, s, imm};
	endfunction

	function automatic logic [word_w-1:0] branch_to(input logic [2:0] cond,
		input logic [21:0] label);
		return {op_b, cond, 2'b00, label};
	endfunction

	function automatic logic [word_w-1:0] jal_to(input logic [21:0] label);
		return {op_jal, 5'd0, label};
	endfunction

	function automatic logic [word_w-1:0] jr_via(input logic [4:0] r);
		return {op_jr, r, 22'd0}; // register sits in the dst field
	endfunction

	function automatic logic [word_w-1:0] halt_word();
		return {op_halt, 27'd0};
	endfunction

	task automatic push_word(input logic [word_w-1:0] w);
		prog[prog_len[5:0]] = w;
		prog_len++;
	endtask

	task automatic check_word(input string name, input logic [word_w-1:0] exp,
		input logic [word_w-1:0] act);
		checks++;
		if (act !== exp) begin
			$display("error: %s expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_store(input string name, input int idx,
		input logic [pc_w-1:0] exp_adr, input logic [word_w-1:0] exp_dat);
		checks++;
		if (idx >= int'(mem.st_cnt)) begin
			$display("%s: store number %0d never appeared on the bus", name, idx);
			errors++;
		end else if (mem.st_adr[idx[3:0]] !== exp_adr || mem.st_dat[idx[3:0]] !== exp_dat) begin
			$display("error: %s store %0d expected %h <- %h actual %h <- %h", name, idx,
				exp_adr, exp_dat, mem.st_adr[idx[3:0]], mem.st_dat[idx[3:0]]);
			errors++;
		end
	endtask

	task automatic expect_reg(input string name, input logic [reg_aw-1:0] r,
		input logic [word_w-1:0] exp);
		@(posedge clk);
		#1;
		dbg_addr = r;
		#2;
		check_word($sformatf("%s r%0d", name, r), exp, dbg_data);
	endtask

	// load, reset, then run until HALT
	task automatic run_program(input string name);
		int n;
		for (int i = 0; i < prog_words; i++) begin
			@(posedge clk);
			#1;
			load_en  = 1'b1;
			load_adr = 8'(i);
			load_dat = (i < prog_len) ? prog[i[5:0]] : {op_halt, 5'd0, 22'(i)}; // filler halts
		end
		@(posedge clk);
		#1;
		load_en = 1'b0;
		rst_n   = 1'b0;
		repeat (4) @(posedge clk);
		#1;
		rst_n = 1'b1;
		n     = 0;
		while (!halted && n < 4000) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (!halted) begin
			$display("timeout: program %s never reached HALT", name);
			errors++;
		end
		prog_len = 0;
	endtask

	task automatic arith_ops();
		logic [16:0]       ia, ib, ic, id;
		logic [word_w-1:0] a, b;
		ia = 17'd1234;
		ib = 17'(-7);
		ic = 17'h10000; // most negative immediate
		id = 17'd300;
		a  = sext17(ia);
		b  = sext17(ib);
		push_word(i_type(op_movi, 1, 0, ia));
		push_word(i_type(op_movi, 2, 0, ib));
		push_word(r_type(op_add, 3, 1, 2));
		push_word(i_type(op_addi, 4, 2, id));
		push_word(r_type(op_sub, 5, 2, 1));
		push_word(i_type(op_subi, 6, 1, ic));
		push_word(halt_word());
		run_program("arith");
		expect_reg("arith", 1, a);
		expect_reg("arith", 2, b);
		expect_reg("arith", 3, a + b);
		expect_reg("arith", 4, b + sext17(id));
		expect_reg("arith", 5, b - a);
		expect_reg("arith", 6, a - sext17(ic));
	endtask

	task automatic logic_and_shifts();
		logic [word_w-1:0] a, b;
		a = sext17(17'h0F0F5);
		b = sext17(17'h18421); // negative so the sign fills the top
		push_word(i_type(op_movi, 1, 0, 17'h0F0F5));
		push_word(i_type(op_movi, 2, 0, 17'h18421));
		push_word(r_type(op_and, 3, 1, 2));
		push_word(r_type(op_or, 4, 1, 2));
		push_word(r_type(op_nor, 5, 1, 2));
		push_word(i_type(op_sll, 6, 1, 17'd4));
		push_word(i_type(op_srl, 7, 2, 17'd8));
		push_word(i_type(op_sra, 8, 2, 17'd8));
		push_word(r_type(op_mov, 9, 1, 0));
		push_word(i_type(op_movi, 0, 0, 17'd55));
		push_word(r_type(op_add, 0, 1, 2));
		push_word(halt_word());
		run_program("logic");
		expect_reg("logic", 3, a & b);
		expect_reg("logic", 4, a | b);
		expect_reg("logic", 5, ~(a | b));
		expect_reg("logic", 6, {a[27:0], 4'd0});
		expect_reg("logic", 7, {8'd0, b[31:8]});
		expect_reg("logic", 8, {{8{b[31]}}, b[31:8]});
		expect_reg("logic", 9, a);
		expect_reg("logic", 0, 32'd0);
	endtask

	task automatic load_store_roundtrip();
		logic [word_w-1:0] base, val;
		base = 32'd150;
		val  = sext17(17'h1ABCD);
		push_word(i_type(op_movi, 1, 0, 17'd150));
		push_word(i_type(op_movi, 2, 0, 17'h1ABCD));
		push_word(i_type(op_sw, 2, 1, 17'd10)); // data register named in the dst field
		push_word(i_type(op_sw, 1, 1, 17'(-5)));
		push_word(i_type(op_lw, 3, 1, 17'd10));
		push_word(i_type(op_lw, 4, 1, 17'(-5)));
		push_word(halt_word());
		run_program("load_store");
		check_word("load_store store count", 32'd2, 32'(mem.st_cnt));
		check_store("load_store", 0, 22'(base + 32'd10), val);
		check_store("load_store", 1, 22'(base - 32'd5), base);
		expect_reg("load_store", 3, val);
		expect_reg("load_store", 4, base);
	endtask

	task automatic cond_branches();
		logic [7:0] taken_mask;
		taken_mask = 8'hDD; // eq and lte fall through
		push_word(i_type(op_movi, 1, 0, 17'd5));
		push_word(i_type(op_movi, 2, 0, 17'(-3)));
		push_word(i_type(op_movi, 3, 0, 17'd1));
		push_word(i_type(op_sll, 3, 3, 17'd31));
		for (int c = 0; c < 8; c++) begin
			case (c)
				0, 1:    push_word(i_type(op_subi, 0, 1, 17'd4)); // positive and nonzero
				2, 5:    push_word(i_type(op_subi, 0, 1, 17'd2));
				3:       push_word(r_type(op_sub, 0, 2, 1)); // negative
				4:       push_word(i_type(op_subi, 0, 1, 17'd5)); // zero
				6:       push_word(i_type(op_subi, 0, 3, 17'd1)); // min int minus one
				default: push_word(i_type(op_addi, 0, 1, 17'd0));
			endcase
			push_word(branch_to(3'(c), 22'(prog_len + 3)));
			push_word(i_type(op_movi, 5'(10 + c), 0, 17'd1));
			push_word(branch_to(cond_uncond, 22'(prog_len + 2)));
			push_word(i_type(op_movi, 5'(10 + c), 0, 17'd2));
		end
		push_word(halt_word());
		run_program("branch");
		for (int c = 0; c < 8; c++) begin
			expect_reg("branch", 5'(10 + c), taken_mask[c[2:0]] ? 32'd2 : 32'd1);
		end
	endtask

	task automatic call_and_return();
		push_word(i_type(op_movi, 20, 0, 17'd1));
		push_word(i_type(op_sll, 20, 20, 17'd22));
		push_word(i_type(op_addi, 20, 20, 17'd10)); // upper bits set and low bits point at 10
		push_word(i_type(op_movi, 1, 0, 17'd1));
		push_word(jal_to(22'd8));
		push_word(i_type(op_addi, 1, 1, 17'd16)); // return point
		push_word(jr_via(20));
		push_word(halt_word());
		push_word(i_type(op_movi, 2, 0, 17'd7)); // subroutine
		push_word(jr_via(link_reg));
		push_word(i_type(op_movi, 3, 0, 17'd9));
		push_word(halt_word());
		run_program("calls");
		expect_reg("calls", 1, 32'd17);
		expect_reg("calls", 2, 32'd7);
		expect_reg("calls", 3, 32'd9);
		expect_reg("calls", 20, 32'h0040000a);
		expect_reg("calls", link_reg, 32'd0);
	endtask

	task automatic halt_hold();
		int bad;
		push_word(i_type(op_movi, 1, 0, 17'd3));
		push_word(halt_word());
		push_word(i_type(op_movi, 1, 0, 17'd4));
		run_program("halt");
		bad = 0;
		repeat (20) begin
			@(posedge clk);
			#4;
			if (!halted || wb_cyc || wb_stb) begin
				bad++;
			end
		end
		checks++;
		if (bad != 0) begin
			$display("halt: the core left the halted state or opened a bus cycle after HALT");
			errors++;
		end
		expect_reg("halt", 1, 32'd3);
	endtask

	initial begin
		rst_n    = 1'b0;
		dbg_addr = '0;
		load_en  = 1'b0;
		load_adr = '0;
		load_dat = '0;
		prog_len = 0;
		errors   = 0;
		checks   = 0;
		arith_ops();
		logic_and_shifts();
		load_store_roundtrip();
		cond_branches();
		call_and_return();
		halt_hold();
		$display("checks: %0d  errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

/* mini_cpu_core.f */
rtl/cpu_cfg_pkg.sv
rtl/cpu_isa_pkg.sv
rtl/reg_file.sv
rtl/instr_decode.sv
rtl/alu_execute.sv
rtl/result_writeback.sv
rtl/fetch_bus_unit.sv
rtl/mini_cpu_core.sv
testbench/tb_bus_memory.sv
testbench/tb_mini_cpu_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the mini_cpu_core testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_mini_cpu_core -f mini_cpu_core.f -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vtb_mini_cpu_core)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "STATUS: PASS"; then
	exit 0
fi
exit 1
